// ==== design/rob_cfg_pkg.sv ====
// --------------------------------------------------
// Reorder buffer configuration
// Sizes of the buffer and its ports, derived widths
// --------------------------------------------------
`default_nettype none

package rob_cfg_pkg;

    // Buffer depth in entries
    localparam int ROB_DEPTH    = 16;

    // Port widths per cycle
    localparam int DP_WIDTH     = 2;
    localparam int CDB_WIDTH    = 2;
    // Retire count shares the dispatch count width, keep RT_WIDTH <= DP_WIDTH
    localparam int RT_WIDTH     = 2;

    // Register files and address width
    localparam int ARCH_REG_NUM = 32;
    localparam int PHY_REG_NUM  = 64;
    localparam int XLEN         = 32;

    // Derived widths
    localparam int ROB_IDX_W    = $clog2(ROB_DEPTH);
    // Counts 0..ROB_DEPTH
    localparam int CNT_W        = $clog2(ROB_DEPTH + 1);
    // Counts 0..DP_WIDTH
    localparam int DP_CNT_W     = $clog2(DP_WIDTH + 1);

endpackage

`default_nettype wire

// ==== design/rob_entry_array.sv ====
// --------------------------------------------------
// Reorder buffer entry storage
// Dispatch, completion, retire and the head window
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module rob_entry_array
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;
(
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  rob_idx_t                        head_i,
    input  rob_idx_t                        tail_i,
    // Dispatch slots
    input  logic      [DP_CNT_W-1:0]        dp_num_i,
    input  addr_t     [DP_WIDTH-1:0]        dp_pc_i,
    input  arch_reg_t [DP_WIDTH-1:0]        dp_rd_i,
    input  phys_tag_t [DP_WIDTH-1:0]        dp_tag_i,
    input  phys_tag_t [DP_WIDTH-1:0]        dp_tag_old_i,
    input  logic      [DP_WIDTH-1:0]        dp_br_predict_i,
    // Completion ports
    input  logic      [CDB_WIDTH-1:0]       cdb_valid_i,
    input  rob_idx_t  [CDB_WIDTH-1:0]       cdb_rob_idx_i,
    input  logic      [CDB_WIDTH-1:0]       cdb_br_taken_i,
    input  addr_t     [CDB_WIDTH-1:0]       cdb_br_target_i,
    // Retire and flush from the select logic
    input  logic      [RT_WIDTH-1:0]        rt_valid_i,
    input  logic                            flush_i,
    // Head window
    output logic      [RT_WIDTH-1:0]        win_done_o,
    output logic      [RT_WIDTH-1:0]        win_mispred_o,
    output addr_t     [RT_WIDTH-1:0]        win_target_o,
    output arch_reg_t [RT_WIDTH-1:0]        rt_arch_reg_o,
    output phys_tag_t [RT_WIDTH-1:0]        rt_tag_o,
    output phys_tag_t [RT_WIDTH-1:0]        rt_tag_old_o,
    output addr_t     [RT_WIDTH-1:0]        rt_pc_o
);

    rob_entry_t entries   [ROB_DEPTH];

    // Per-entry decode of this cycle's requests
    logic       dp_hit    [ROB_DEPTH];
    rob_entry_t dp_entry  [ROB_DEPTH];
    logic       rt_hit    [ROB_DEPTH];
    logic       cp_hit    [ROB_DEPTH];
    logic       cp_taken  [ROB_DEPTH];
    addr_t      cp_target [ROB_DEPTH];

    // --------------------------------------------------
    // Request decode
    // --------------------------------------------------
    // Dispatch slot k writes entry tail + k
    always_comb begin : dp_decode
        rob_idx_t w;
        for (int e = 0; e < ROB_DEPTH; e++) begin
            dp_hit[e]   = 1'b0;
            dp_entry[e] = '0;
        end
        for (int k = 0; k < DP_WIDTH; k++) begin
            w = idx_add(tail_i, k);
            if (DP_CNT_W'(k) < dp_num_i) begin
                dp_hit[w]              = 1'b1;
                dp_entry[w].valid      = 1'b1;
                dp_entry[w].pc         = dp_pc_i[k];
                dp_entry[w].rd         = dp_rd_i[k];
                dp_entry[w].tag        = dp_tag_i[k];
                dp_entry[w].tag_old    = dp_tag_old_i[k];
                dp_entry[w].br_predict = dp_br_predict_i[k];
            end
        end
    end

    // Retire slot k clears entry head + k
    always_comb begin
        for (int e = 0; e < ROB_DEPTH; e++) begin
            rt_hit[e] = 1'b0;
        end
        for (int k = 0; k < RT_WIDTH; k++) begin
            if (rt_valid_i[k]) begin
                rt_hit[idx_add(head_i, k)] = 1'b1;
            end
        end
    end

    // Completion by index, higher port wins on a collision
    always_comb begin
        for (int e = 0; e < ROB_DEPTH; e++) begin
            cp_hit[e]    = 1'b0;
            cp_taken[e]  = 1'b0;
            cp_target[e] = '0;
        end
        for (int p = 0; p < CDB_WIDTH; p++) begin
            if (cdb_valid_i[p]) begin
                cp_hit[cdb_rob_idx_i[p]]    = 1'b1;
                cp_taken[cdb_rob_idx_i[p]]  = cdb_br_taken_i[p];
                cp_target[cdb_rob_idx_i[p]] = cdb_br_target_i[p];
            end
        end
    end

    // --------------------------------------------------
    // Entry update
    // --------------------------------------------------
    // Priority is flush, dispatch, retire, then completion
    always_ff @(posedge clk_i) begin
        for (int e = 0; e < ROB_DEPTH; e++) begin
            if (rst_i || flush_i) begin
                entries[e].valid    <= 1'b0;
                entries[e].complete <= 1'b0;
            end else if (dp_hit[e]) begin
                entries[e] <= dp_entry[e];
            end else if (rt_hit[e]) begin
                entries[e].valid    <= 1'b0;
                entries[e].complete <= 1'b0;
            end else if (cp_hit[e] && entries[e].valid) begin
                // Completion of an empty slot is dropped
                entries[e].complete  <= 1'b1;
                entries[e].br_result <= cp_taken[e];
                entries[e].br_target <= cp_target[e];
            end
        end
    end

    // Head window read
    always_comb begin : win_read
        rob_entry_t cur;
        for (int k = 0; k < RT_WIDTH; k++) begin
            cur              = entries[idx_add(head_i, k)];
            win_done_o[k]    = cur.valid & cur.complete;
            // Outcome differs from the prediction
            win_mispred_o[k] = cur.valid & cur.complete & (cur.br_predict != cur.br_result);
            win_target_o[k]  = cur.br_target;
            rt_arch_reg_o[k] = cur.rd;
            rt_tag_o[k]      = cur.tag;
            rt_tag_old_o[k]  = cur.tag_old;
            rt_pc_o[k]       = cur.pc;
        end
    end

endmodule

`default_nettype wire

// ==== design/rob_pointers.sv ====
// --------------------------------------------------
// Reorder buffer pointers
// Head, tail, occupancy and the dispatch credit
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module rob_pointers
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;
(
    input  logic                            clk_i,
    input  logic                            rst_i,
    // Instructions entering at the tail this cycle
    input  logic     [DP_CNT_W-1:0]         dp_num_i,
    // Entries leaving from the head this cycle
    input  logic     [DP_CNT_W-1:0]         rt_num_i,
    input  logic                            flush_i,
    output rob_idx_t                        head_o,
    output rob_idx_t                        tail_o,
    output logic     [DP_CNT_W-1:0]         dp_credit_o,
    output rob_idx_t [DP_WIDTH-1:0]         dp_rob_idx_o
);

    rob_idx_t head_q;
    rob_idx_t tail_q;
    // Occupied entries, stands in for the wrap bits
    rob_cnt_t count_q;
    // Free entries plus those retiring now
    rob_cnt_t avail;

    // --------------------------------------------------
    // Pointer and occupancy registers
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            // Flush empties the buffer, so both pointers restart at 0
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= idx_add(head_q, rt_num_i);
            tail_q  <= idx_add(tail_q, dp_num_i);
            count_q <= count_q + rob_cnt_t'(dp_num_i) - rob_cnt_t'(rt_num_i);
        end
    end

    // --------------------------------------------------
    // Dispatch credit
    // --------------------------------------------------
    always_comb begin
        // Retiring entries free up in time for this edge's dispatch
        avail = rob_cnt_t'(ROB_DEPTH) - count_q + rob_cnt_t'(rt_num_i);
        // Clamp to the dispatch width
        if (avail > rob_cnt_t'(DP_WIDTH)) begin
            dp_credit_o = DP_CNT_W'(DP_WIDTH);
        end else begin
            dp_credit_o = avail[DP_CNT_W-1:0];
        end
    end

    // Slot k lands at tail + k, published whether used or not
    always_comb begin
        for (int k = 0; k < DP_WIDTH; k++) begin
            dp_rob_idx_o[k] = idx_add(tail_q, k);
        end
    end

    assign head_o = head_q;
    assign tail_o = tail_q;

endmodule

`default_nettype wire

// ==== design/rob_retire_select.sv ====
// --------------------------------------------------
// Reorder buffer retire select
// In-order retire chain and flush generation
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module rob_retire_select
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;
(
    input  logic                            exception_i,
    // Head window state
    input  logic  [RT_WIDTH-1:0]            win_done_i,
    input  logic  [RT_WIDTH-1:0]            win_mispred_i,
    input  addr_t [RT_WIDTH-1:0]            win_target_i,
    output logic  [RT_WIDTH-1:0]            rt_valid_o,
    output logic  [DP_CNT_W-1:0]            rt_num_o,
    output logic                            flush_o,
    output logic                            br_redirect_o,
    output addr_t                           br_target_o
);

    logic  redirect;
    addr_t redirect_target;

    // Retire chain, stops at the first incomplete entry or after a mispredict
    always_comb begin : chain_build
        logic [RT_WIDTH-1:0] chain;
        chain[0] = win_done_i[0];
        for (int k = 1; k < RT_WIDTH; k++) begin
            chain[k] = win_done_i[k] & chain[k-1] & ~win_mispred_i[k-1];
        end
        rt_valid_o = chain;
    end

    // Count of retiring slots
    always_comb begin
        rt_num_o = '0;
        for (int k = 0; k < RT_WIDTH; k++) begin
            if (rt_valid_o[k]) begin
                rt_num_o = rt_num_o + DP_CNT_W'(1);
            end
        end
    end

    // First retiring mispredict, at most one given the chain rule
    always_comb begin
        redirect        = 1'b0;
        redirect_target = '0;
        for (int k = 0; k < RT_WIDTH; k++) begin
            if (!redirect && rt_valid_o[k] && win_mispred_i[k]) begin
                redirect        = 1'b1;
                redirect_target = win_target_i[k];
            end
        end
    end

    // Exception flushes without redirecting fetch
    assign flush_o       = exception_i | redirect;
    assign br_redirect_o = redirect & ~exception_i;
    assign br_target_o   = redirect_target;

endmodule

`default_nettype wire

// ==== design/rob_top.sv ====
// --------------------------------------------------
// Superscalar reorder buffer
// Pointers, entry storage and retire select
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module rob_top
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;
(
    input  logic                            clk_i,
    input  logic                            rst_i,
    // Dispatch
    input  logic      [DP_CNT_W-1:0]        dp_num_i,
    input  addr_t     [DP_WIDTH-1:0]        dp_pc_i,
    input  arch_reg_t [DP_WIDTH-1:0]        dp_rd_i,
    input  phys_tag_t [DP_WIDTH-1:0]        dp_tag_i,
    input  phys_tag_t [DP_WIDTH-1:0]        dp_tag_old_i,
    input  logic      [DP_WIDTH-1:0]        dp_br_predict_i,
    output rob_idx_t  [DP_WIDTH-1:0]        dp_rob_idx_o,
    // Slots the dispatcher may fill this cycle
    output logic      [DP_CNT_W-1:0]        dp_credit_o,
    // Completion
    input  logic      [CDB_WIDTH-1:0]       cdb_valid_i,
    input  rob_idx_t  [CDB_WIDTH-1:0]       cdb_rob_idx_i,
    input  logic      [CDB_WIDTH-1:0]       cdb_br_taken_i,
    input  addr_t     [CDB_WIDTH-1:0]       cdb_br_target_i,
    // Retire
    output logic      [RT_WIDTH-1:0]        rt_valid_o,
    output arch_reg_t [RT_WIDTH-1:0]        rt_arch_reg_o,
    output phys_tag_t [RT_WIDTH-1:0]        rt_tag_o,
    output phys_tag_t [RT_WIDTH-1:0]        rt_tag_old_o,
    output addr_t     [RT_WIDTH-1:0]        rt_pc_o,
    // Flush
    input  logic                            exception_i,
    output logic                            flush_o,
    output logic                            br_redirect_o,
    output addr_t                           br_target_o
);

    rob_idx_t                head;
    rob_idx_t                tail;
    logic  [RT_WIDTH-1:0]    win_done;
    logic  [RT_WIDTH-1:0]    win_mispred;
    addr_t [RT_WIDTH-1:0]    win_target;
    logic  [DP_CNT_W-1:0]    rt_num;

    rob_pointers u_pointers (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .dp_num_i     (dp_num_i),
        .rt_num_i     (rt_num),
        .flush_i      (flush_o),
        .head_o       (head),
        .tail_o       (tail),
        .dp_credit_o  (dp_credit_o),
        .dp_rob_idx_o (dp_rob_idx_o)
    );

    rob_entry_array u_entry_array (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .head_i          (head),
        .tail_i          (tail),
        .dp_num_i        (dp_num_i),
        .dp_pc_i         (dp_pc_i),
        .dp_rd_i         (dp_rd_i),
        .dp_tag_i        (dp_tag_i),
        .dp_tag_old_i    (dp_tag_old_i),
        .dp_br_predict_i (dp_br_predict_i),
        .cdb_valid_i     (cdb_valid_i),
        .cdb_rob_idx_i   (cdb_rob_idx_i),
        .cdb_br_taken_i  (cdb_br_taken_i),
        .cdb_br_target_i (cdb_br_target_i),
        .rt_valid_i      (rt_valid_o),
        .flush_i         (flush_o),
        .win_done_o      (win_done),
        .win_mispred_o   (win_mispred),
        .win_target_o    (win_target),
        .rt_arch_reg_o   (rt_arch_reg_o),
        .rt_tag_o        (rt_tag_o),
        .rt_tag_old_o    (rt_tag_old_o),
        .rt_pc_o         (rt_pc_o)
    );

    // Combinational, closes the loop back into pointers and array
    rob_retire_select u_retire_select (
        .exception_i   (exception_i),
        .win_done_i    (win_done),
        .win_mispred_i (win_mispred),
        .win_target_i  (win_target),
        .rt_valid_o    (rt_valid_o),
        .rt_num_o      (rt_num),
        .flush_o       (flush_o),
        .br_redirect_o (br_redirect_o),
        .br_target_o   (br_target_o)
    );

endmodule

`default_nettype wire

// ==== design/rob_types_pkg.sv ====
// --------------------------------------------------
// Reorder buffer types
// Index, tag, register, address and entry layout
// --------------------------------------------------
`default_nettype none

package rob_types_pkg;

    import rob_cfg_pkg::*;

    typedef logic [ROB_IDX_W-1:0]             rob_idx_t;
    typedef logic [CNT_W-1:0]                 rob_cnt_t;
    typedef logic [$clog2(PHY_REG_NUM)-1:0]   phys_tag_t;
    typedef logic [$clog2(ARCH_REG_NUM)-1:0]  arch_reg_t;
    typedef logic [XLEN-1:0]                  addr_t;

    // One stored instruction
    typedef struct packed {
        logic      valid;
        logic      complete;
        addr_t     pc;
        arch_reg_t rd;
        phys_tag_t tag;
        phys_tag_t tag_old;
        // Predicted taken at dispatch
        logic      br_predict;
        // Actual outcome, written at completion
        logic      br_result;
        addr_t     br_target;
    } rob_entry_t;

    // Circular index step, wraps at ROB_DEPTH even when not a power of two
    function automatic rob_idx_t idx_add(input rob_idx_t base, input int unsigned off);
        logic [ROB_IDX_W:0] sum;
        sum = {1'b0, base} + (ROB_IDX_W + 1)'(off);
        if (sum >= (ROB_IDX_W + 1)'(ROB_DEPTH)) begin
            sum = sum - (ROB_IDX_W + 1)'(ROB_DEPTH);
        end
        return rob_idx_t'(sum);
    endfunction

endpackage

`default_nettype wire

// ==== rob_top.f ====
design/rob_cfg_pkg.sv
design/rob_types_pkg.sv
design/rob_pointers.sv
design/rob_entry_array.sv
design/rob_retire_select.sv
design/rob_top.sv
testbench/rob_properties.sv
testbench/tb_rob_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rob_top -f rob_top.f \
    && ./obj_dir/Vtb_rob_top | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "Run passed" \
    || { echo "Run failed"; exit 1; }

// ==== testbench/rob_properties.sv ====
// --------------------------------------------------
// Reorder buffer protocol assertions
// Credit use, retire prefix and flush length
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module rob_properties
    import rob_cfg_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic [DP_CNT_W-1:0] dp_num_i,
    input  logic [DP_CNT_W-1:0] dp_credit_i,
    input  logic [RT_WIDTH-1:0] rt_valid_i,
    input  logic                flush_i
);

    // Dispatcher stays within the published credit
    credit_respected: assert property (
        @(posedge clk_i) disable iff (rst_i) dp_num_i <= dp_credit_i
    ) else $error("dispatch count above credit");

    // Valid slots contiguous from slot 0
    retire_prefix: assert property (
        @(posedge clk_i) disable iff (rst_i)
        ((rt_valid_i + RT_WIDTH'(1)) & rt_valid_i) == '0
    ) else $error("retire valids not a prefix");

    // Flush empties the buffer, so no second cycle
    flush_one_cycle: assert property (
        @(posedge clk_i) disable iff (rst_i) flush_i |=> !flush_i
    ) else $error("flush held for two cycles");

endmodule

bind rob_top rob_properties u_properties (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .dp_num_i    (dp_num_i),
    .dp_credit_i (dp_credit_o),
    .rt_valid_i  (rt_valid_o),
    .flush_i     (flush_o)
);

`default_nettype wire

// ==== testbench/tb_rob_top.sv ====
// --------------------------------------------------
// Reorder buffer testbench
// Directed tests against a queue model of the ROB
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_rob_top
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_INSTR = 200;
    // Rough cycle count of reset plus all tests
    localparam int RUN_CYCLES   = RESET_CYCLES + 150 + 4 * RANDOM_INSTR;
    localparam int WATCHDOG_NS  = (RUN_CYCLES + 200) * CLK_PERIOD;

    // DUT ports
    logic                     clk_i;
    logic                     rst_i;
    logic      [DP_CNT_W-1:0] dp_num_i;
    addr_t     [DP_WIDTH-1:0] dp_pc_i;
    arch_reg_t [DP_WIDTH-1:0] dp_rd_i;
    phys_tag_t [DP_WIDTH-1:0] dp_tag_i;
    phys_tag_t [DP_WIDTH-1:0] dp_tag_old_i;
    logic      [DP_WIDTH-1:0] dp_br_predict_i;
    rob_idx_t  [DP_WIDTH-1:0] dp_rob_idx_o;
    logic      [DP_CNT_W-1:0] dp_credit_o;
    logic     [CDB_WIDTH-1:0] cdb_valid_i;
    rob_idx_t [CDB_WIDTH-1:0] cdb_rob_idx_i;
    logic     [CDB_WIDTH-1:0] cdb_br_taken_i;
    addr_t    [CDB_WIDTH-1:0] cdb_br_target_i;
    logic      [RT_WIDTH-1:0] rt_valid_o;
    arch_reg_t [RT_WIDTH-1:0] rt_arch_reg_o;
    phys_tag_t [RT_WIDTH-1:0] rt_tag_o;
    phys_tag_t [RT_WIDTH-1:0] rt_tag_old_o;
    addr_t     [RT_WIDTH-1:0] rt_pc_o;
    logic                     exception_i;
    logic                     flush_o;
    logic                     br_redirect_o;
    addr_t                    br_target_o;

    // One in-flight instruction of the model
    typedef struct packed {
        rob_idx_t  idx;
        addr_t     pc;
        arch_reg_t rd;
        phys_tag_t tag;
        phys_tag_t tag_old;
        logic      pred;
        logic      done;
        logic      mispred;
        addr_t     target;
    } instr_t;

    // Program order with the oldest at the front
    instr_t   model_q [$];
    rob_idx_t m_tail;
    int       seed;

    // Stimulus for the next cycle
    int                       stg_num;
    instr_t                   stg_dp [DP_WIDTH];
    logic     [CDB_WIDTH-1:0] stg_cv;
    rob_idx_t [CDB_WIDTH-1:0] stg_cidx;
    logic     [CDB_WIDTH-1:0] stg_ctaken;
    addr_t    [CDB_WIDTH-1:0] stg_ctgt;
    logic                     stg_exc;

    rob_top DUT (.*);

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // --------------------------------------------------
    // Checking and model helpers
    // --------------------------------------------------
    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "first error, run stopped");
        end
    endtask

    function automatic rob_idx_t wrap_idx(input rob_idx_t base, input int off);
        return rob_idx_t'((int'(base) + off) % ROB_DEPTH);
    endfunction

    // Completed entries at the head up to the first mispredict
    function automatic int retire_count();
        int n;
        n = 0;
        while (n < RT_WIDTH && n < model_q.size() && model_q[n].done) begin
            n++;
            if (model_q[n-1].mispred) break;
        end
        return n;
    endfunction

    function automatic int credit_now();
        int avail;
        avail = ROB_DEPTH - model_q.size() + retire_count();
        return (avail > DP_WIDTH) ? DP_WIDTH : avail;
    endfunction

    task automatic stage_dispatch(input logic pred);
        instr_t ins;
        ins             = '0;
        ins.pc          = addr_t'($random(seed));
        ins.rd          = arch_reg_t'($random(seed));
        ins.tag         = phys_tag_t'($random(seed));
        ins.tag_old     = phys_tag_t'($random(seed));
        ins.pred        = pred;
        stg_dp[stg_num] = ins;
        stg_num++;
    endtask

    task automatic stage_complete(input int port, input rob_idx_t idx, input logic taken,
                                  input addr_t target);
        stg_cv[port]     = 1'b1;
        stg_cidx[port]   = idx;
        stg_ctaken[port] = taken;
        stg_ctgt[port]   = target;
    endtask

    // Up to CDB_WIDTH open entries in age order or shuffled
    task automatic stage_open_completions(input bit shuffle);
        int open [$];
        int pick;
        for (int i = 0; i < model_q.size(); i++) begin
            if (!model_q[i].done) open.push_back(i);
        end
        for (int p = 0; p < CDB_WIDTH && open.size() > 0; p++) begin
            pick = shuffle ? $unsigned($random(seed)) % open.size() : 0;
            stage_complete(p, model_q[open[pick]].idx, 1'b0, '0);
            open.delete(pick);
        end
    endtask

    // Model of the next edge
    // Flush discards dispatch and completion
    function automatic void update_model(input int ret, input logic flush);
        instr_t ins;
        repeat (ret) ins = model_q.pop_front();
        if (flush) begin
            model_q.delete();
            m_tail = '0;
        end else begin
            for (int p = 0; p < CDB_WIDTH; p++) begin
                for (int i = 0; i < model_q.size(); i++) begin
                    if (stg_cv[p] && model_q[i].idx == stg_cidx[p]) begin
                        ins         = model_q[i];
                        ins.done    = 1'b1;
                        ins.mispred = (stg_ctaken[p] != ins.pred);
                        ins.target  = stg_ctgt[p];
                        model_q[i]  = ins;
                    end
                end
            end
            for (int k = 0; k < stg_num; k++) begin
                ins     = stg_dp[k];
                ins.idx = m_tail;
                model_q.push_back(ins);
                m_tail  = wrap_idx(m_tail, 1);
            end
        end
        stg_num = 0;
        stg_cv  = '0;
        stg_exc = 1'b0;
    endfunction

    // Drive staged inputs on the edge and check outputs mid-cycle
    task automatic run_cycle();
        int                       ret;
        int                       credit;
        logic                     mis;
        addr_t                    mis_tgt;
        instr_t                   ins;
        addr_t     [DP_WIDTH-1:0] pc_v;
        arch_reg_t [DP_WIDTH-1:0] rd_v;
        phys_tag_t [DP_WIDTH-1:0] tag_v;
        phys_tag_t [DP_WIDTH-1:0] old_v;
        logic      [DP_WIDTH-1:0] pred_v;
        ret     = retire_count();
        credit  = credit_now();
        mis     = 1'b0;
        mis_tgt = '0;
        pc_v    = '0;
        rd_v    = '0;
        tag_v   = '0;
        old_v   = '0;
        pred_v  = '0;
        for (int k = 0; k < stg_num; k++) begin
            pc_v[k]   = stg_dp[k].pc;
            rd_v[k]   = stg_dp[k].rd;
            tag_v[k]  = stg_dp[k].tag;
            old_v[k]  = stg_dp[k].tag_old;
            pred_v[k] = stg_dp[k].pred;
        end
        @(posedge clk_i);
        dp_num_i        <= DP_CNT_W'(stg_num);
        dp_pc_i         <= pc_v;
        dp_rd_i         <= rd_v;
        dp_tag_i        <= tag_v;
        dp_tag_old_i    <= old_v;
        dp_br_predict_i <= pred_v;
        cdb_valid_i     <= stg_cv;
        cdb_rob_idx_i   <= stg_cidx;
        cdb_br_taken_i  <= stg_ctaken;
        cdb_br_target_i <= stg_ctgt;
        exception_i     <= stg_exc;
        @(negedge clk_i);
        check_value(64'(dp_credit_o), 64'(credit), "dispatch credit");
        for (int k = 0; k < DP_WIDTH; k++) begin
            check_value(64'(dp_rob_idx_o[k]), 64'(wrap_idx(m_tail, k)), "dispatch index");
        end
        for (int k = 0; k < RT_WIDTH; k++) begin
            check_value(64'(rt_valid_o[k]), 64'(k < ret), "retire valid");
            if (k < ret) begin
                ins = model_q[k];
                check_value(64'(rt_pc_o[k]), 64'(ins.pc), "retire pc");
                check_value(64'(rt_arch_reg_o[k]), 64'(ins.rd), "retire rd");
                check_value(64'(rt_tag_o[k]), 64'(ins.tag), "retire tag");
                check_value(64'(rt_tag_old_o[k]), 64'(ins.tag_old), "retire old tag");
                if (ins.mispred) begin
                    mis     = 1'b1;
                    mis_tgt = ins.target;
                end
            end
        end
        check_value(64'(flush_o), 64'(stg_exc | mis), "flush");
        check_value(64'(br_redirect_o), 64'(mis & ~stg_exc), "redirect");
        if (mis) check_value(64'(br_target_o), 64'(mis_tgt), "redirect target");
        update_model(ret, stg_exc | mis);
    endtask

    task automatic drain();
        while (model_q.size() > 0) begin
            stage_open_completions(1'b0);
            run_cycle();
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset_state();
        repeat (3) run_cycle();
        check_value(64'(dp_credit_o), 64'(DP_WIDTH), "credit after reset");
        check_value(64'(rt_valid_o), 64'(0), "retire valid after reset");
        check_value(64'(flush_o), 64'(0), "flush after reset");
    endtask

    task automatic test_out_of_order();
        repeat (2) begin
            repeat (DP_WIDTH) stage_dispatch(1'b0);
            run_cycle();
        end
        // Youngest pair first
        stage_complete(0, model_q[3].idx, 1'b0, '0);
        stage_complete(1, model_q[2].idx, 1'b0, '0);
        run_cycle();
        stage_complete(0, model_q[1].idx, 1'b0, '0);
        run_cycle();
        run_cycle();
        check_value(64'(rt_valid_o), 64'(0), "retire before oldest completes");
        stage_complete(0, model_q[0].idx, 1'b0, '0);
        run_cycle();
        run_cycle();
        check_value(64'(rt_valid_o), 64'(2'b11), "first retire pair");
        run_cycle();
        check_value(64'(rt_valid_o), 64'(2'b11), "second retire pair");
    endtask

    task automatic test_credit();
        int n;
        while (model_q.size() < ROB_DEPTH) begin
            n = credit_now();
            repeat (n) stage_dispatch(1'b0);
            run_cycle();
        end
        run_cycle();
        check_value(64'(dp_credit_o), 64'(0), "credit when full");
        stage_complete(0, model_q[0].idx, 1'b0, '0);
        run_cycle();
        check_value(64'(dp_credit_o), 64'(0), "credit before head retires");
        run_cycle();
        check_value(64'(dp_credit_o), 64'(1), "credit as head retires");
        drain();
    endtask

    task automatic test_mispredict();
        addr_t target;
        target = addr_t'($random(seed));
        // Branch predicted taken and a younger op
        stage_dispatch(1'b1);
        stage_dispatch(1'b0);
        run_cycle();
        // Full buffer, so the credit after the flush needs the count cleared
        while (model_q.size() < ROB_DEPTH) begin
            repeat (credit_now()) stage_dispatch(1'b0);
            run_cycle();
        end
        stage_complete(0, model_q[0].idx, 1'b0, target);
        stage_complete(1, model_q[1].idx, 1'b0, '0);
        run_cycle();
        run_cycle();
        check_value(64'(flush_o), 64'(1), "flush on mispredict");
        check_value(64'(br_redirect_o), 64'(1), "redirect on mispredict");
        check_value(64'(br_target_o), 64'(target), "redirect target");
        check_value(64'(rt_valid_o), 64'(2'b01), "only the branch retires");
        run_cycle();
        check_value(64'(dp_credit_o), 64'(DP_WIDTH), "credit after flush");
        check_value(64'(dp_rob_idx_o[0]), 64'(0), "dispatch index after flush");
    endtask

    task automatic test_exception();
        rob_idx_t old_idx [3];
        repeat (DP_WIDTH) stage_dispatch(1'b0);
        run_cycle();
        // Younger entry done while the head stays open
        stage_dispatch(1'b0);
        stage_complete(0, model_q[1].idx, 1'b0, '0);
        run_cycle();
        for (int i = 0; i < 3; i++) begin
            old_idx[i] = model_q[i].idx;
        end
        stg_exc = 1'b1;
        run_cycle();
        check_value(64'(flush_o), 64'(1), "flush on exception");
        check_value(64'(br_redirect_o), 64'(0), "no redirect on exception");
        repeat (3) begin
            // Late completions of flushed entries
            stage_complete(0, old_idx[0], 1'b0, '0);
            stage_complete(1, old_idx[2], 1'b0, '0);
            run_cycle();
            check_value(64'(rt_valid_o), 64'(0), "retire after exception");
        end
        check_value(64'(dp_rob_idx_o[0]), 64'(0), "dispatch index after exception");
    endtask

    task automatic test_random_traffic();
        int sent;
        int n;
        sent = 0;
        while (sent < RANDOM_INSTR || model_q.size() > 0) begin
            n = $unsigned($random(seed)) % (DP_WIDTH + 1);
            if (n > credit_now()) n = credit_now();
            if (n > RANDOM_INSTR - sent) n = RANDOM_INSTR - sent;
            repeat (n) stage_dispatch(1'b0);
            sent += n;
            if (($random(seed) & 3) != 0) stage_open_completions(1'b1);
            run_cycle();
        end
    endtask

    // --------------------------------------------------
    // Sequence and watchdog
    // --------------------------------------------------
    initial begin
        seed            = 32'h4849;
        rst_i           = 1'b1;
        dp_num_i        = '0;
        dp_pc_i         = '0;
        dp_rd_i         = '0;
        dp_tag_i        = '0;
        dp_tag_old_i    = '0;
        dp_br_predict_i = '0;
        cdb_valid_i     = '0;
        cdb_rob_idx_i   = '0;
        cdb_br_taken_i  = '0;
        cdb_br_target_i = '0;
        exception_i     = 1'b0;
        stg_num         = 0;
        stg_cv          = '0;
        stg_cidx        = '0;
        stg_ctaken      = '0;
        stg_ctgt        = '0;
        stg_exc         = 1'b0;
        m_tail          = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        test_reset_state();
        test_out_of_order();
        test_credit();
        test_mispredict();
        test_exception();
        test_random_traffic();
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
